/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the pulse timer testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

rm -rf "$OBJ_DIR" "$LOG"

verilator --binary --timing --assert -f src.f --top-module pulse_timer_tb \
    -Mdir "$OBJ_DIR" -o vsim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ_DIR/vsim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

/* source/pulse_cfg_regs.sv */
module pulse_cfg_regs #(
    parameter int NUM_CH = 2
) (
    input  logic                                          sys_clk,
    input  logic                                          sys_rst,
    input  logic                                          i_req,
    input  logic                                          i_we,
    input  pulse_timer_pkg::reg_addr_t                    i_addr,
    input  logic [pulse_timer_pkg::REG_DATA_W-1:0]        i_wdata,
    output logic                                          o_ack,
    output logic [pulse_timer_pkg::REG_DATA_W-1:0]        o_rdata,
    output logic [NUM_CH-1:0]                             o_enable,
    output logic [NUM_CH*pulse_timer_pkg::SRATE_W-1:0]    o_srate_div,
    output logic [NUM_CH*pulse_timer_pkg::PERIOD_W-1:0]   o_period,
    output logic [NUM_CH*pulse_timer_pkg::DELAY_W-1:0]    o_delay,
    output logic [NUM_CH*pulse_timer_pkg::WIDTH_W-1:0]    o_width
);

    localparam int AW = pulse_timer_pkg::REG_ADDR_W;
    localparam int DW = pulse_timer_pkg::REG_DATA_W;
    localparam int SW = pulse_timer_pkg::SRATE_W;
    localparam int PW = pulse_timer_pkg::PERIOD_W;
    localparam int LW = pulse_timer_pkg::DELAY_W;
    localparam int WW = pulse_timer_pkg::WIDTH_W;

    // Channel block layout, taken from the address map
    localparam int CH_BASE    = int'(pulse_timer_pkg::REG_CH0_SRATE);
    localparam int CH_STRIDE  = int'(pulse_timer_pkg::REG_CH1_SRATE) - CH_BASE;
    localparam int OFS_PERIOD = int'(pulse_timer_pkg::REG_CH0_PERIOD) - CH_BASE;
    localparam int OFS_DELAY  = int'(pulse_timer_pkg::REG_CH0_DELAY) - CH_BASE;
    localparam int OFS_WIDTH  = int'(pulse_timer_pkg::REG_CH0_WIDTH) - CH_BASE;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } hs_state_t;

    hs_state_t         state_q;
    logic              access;
    logic              wr_en;
    logic              hit_ctrl;
    logic [AW-1:0]     addr_raw;
    logic [NUM_CH-1:0] enable_q;
    logic [DW-1:0]     rd_ch [NUM_CH];
    logic [DW-1:0]     rd_mux;
    logic [DW-1:0]     rdata_q;

    // ------------------------------
    // Four-phase handshake
    // ------------------------------
    // Access happens once, on the idle-to-ack edge
    assign access = (state_q == ST_IDLE) && i_req;
    assign wr_en  = access && i_we;

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (i_req) state_q <= ST_ACK;
                ST_ACK:  if (!i_req) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign o_ack = (state_q == ST_ACK);

    // ------------------------------
    // Control word
    // ------------------------------
    assign addr_raw = i_addr;
    assign hit_ctrl = (i_addr == pulse_timer_pkg::REG_CTRL);

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            enable_q <= '0;
        end else if (wr_en && hit_ctrl) begin
            enable_q <= i_wdata[NUM_CH-1:0];
        end
    end

    assign o_enable = enable_q;

    // ------------------------------
    // Per-channel fields
    // ------------------------------
    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
        localparam int BASE = CH_BASE + c * CH_STRIDE;

        logic          hit_srate;
        logic          hit_period;
        logic          hit_delay;
        logic          hit_width;
        logic [SW-1:0] srate_q;
        logic [PW-1:0] period_q;
        logic [LW-1:0] delay_q;
        logic [WW-1:0] width_q;

        assign hit_srate  = (addr_raw == AW'(BASE));
        assign hit_period = (addr_raw == AW'(BASE + OFS_PERIOD));
        assign hit_delay  = (addr_raw == AW'(BASE + OFS_DELAY));
        assign hit_width  = (addr_raw == AW'(BASE + OFS_WIDTH));

        // Upper write bits dropped by the slice
        always_ff @(posedge sys_clk) begin
            if (sys_rst) begin
                srate_q  <= '0;
                period_q <= '0;
                delay_q  <= '0;
                width_q  <= '0;
            end else if (wr_en) begin
                if (hit_srate) srate_q <= i_wdata[SW-1:0];
                if (hit_period) period_q <= i_wdata[PW-1:0];
                if (hit_delay) delay_q <= i_wdata[LW-1:0];
                if (hit_width) width_q <= i_wdata[WW-1:0];
            end
        end

        // Zero-extended readback, only the selected field survives
        assign rd_ch[c] = ({DW{hit_srate}} & DW'(srate_q))
                        | ({DW{hit_period}} & DW'(period_q))
                        | ({DW{hit_delay}} & DW'(delay_q))
                        | ({DW{hit_width}} & DW'(width_q));

        assign o_srate_div[c*SW +: SW] = srate_q;
        assign o_period[c*PW +: PW]    = period_q;
        assign o_delay[c*LW +: LW]     = delay_q;
        assign o_width[c*WW +: WW]     = width_q;
    end

    // ------------------------------
    // Read path
    // ------------------------------
    // Unmapped address selects nothing, reads zero
    always_comb begin
        rd_mux = hit_ctrl ? DW'(enable_q) : '0;
        for (int c = 0; c < NUM_CH; c++) begin
            rd_mux = rd_mux | rd_ch[c];
        end
    end

    // Captured with the access, held through ack
    always_ff @(posedge sys_clk) begin
        if (access) begin
            rdata_q <= rd_mux;
        end
    end

    assign o_rdata = rdata_q;

endmodule

/* source/pulse_channel.sv */
module pulse_channel (
    input  logic                                 sys_clk,
    input  logic                                 sys_rst,
    input  logic                                 i_enable,
    input  logic [pulse_timer_pkg::SRATE_W-1:0]  i_srate_div,
    input  logic [pulse_timer_pkg::PERIOD_W-1:0] i_period,
    input  logic [pulse_timer_pkg::DELAY_W-1:0]  i_delay,
    input  logic [pulse_timer_pkg::WIDTH_W-1:0]  i_width,
    output logic                                 o_strobe,
    output logic                                 o_ref,
    output logic                                 o_pulse
);

    localparam int WFMR_W = pulse_timer_pkg::WIDTH_W + 1;

    logic              clear;
    logic              strobe;
    logic              ref_mark;
    logic              delay_z;
    logic [WFMR_W-1:0] width_reload;

    // Whole chain parked at zero while off
    assign clear = ~i_enable;

    // Former counts width+1 strobes
    // Pulse then covers at least width full sample periods
    assign width_reload = WFMR_W'(i_width) + 1'b1;

    // ------------------------------
    // Sample-rate prescaler
    // ------------------------------
    timing_counter #(
        .CNT_W (pulse_timer_pkg::SRATE_W),
        .MODE  (pulse_timer_pkg::CNT_AUTORELOAD)
    ) u_srate_psc (
        .i_clk_sys (sys_clk),
        .sys_rst   (sys_rst),
        .i_clear   (clear),
        .i_en      (1'b1),
        .i_load    (1'b0),
        .i_reload  (i_srate_div),
        .o_carry   (strobe),
        .o_zpulse  (),
        .o_nzero   ()
    );

    // ------------------------------
    // Pulse period prescaler
    // ------------------------------
    // Steps once per sample strobe
    timing_counter #(
        .CNT_W (pulse_timer_pkg::PERIOD_W),
        .MODE  (pulse_timer_pkg::CNT_AUTORELOAD)
    ) u_period_psc (
        .i_clk_sys (sys_clk),
        .sys_rst   (sys_rst),
        .i_clear   (clear),
        .i_en      (strobe),
        .i_load    (1'b0),
        .i_reload  (i_period),
        .o_carry   (ref_mark),
        .o_zpulse  (),
        .o_nzero   ()
    );

    // ------------------------------
    // Delay one-shot, sys_clk units
    // ------------------------------
    timing_counter #(
        .CNT_W (pulse_timer_pkg::DELAY_W),
        .MODE  (pulse_timer_pkg::CNT_ONESHOT)
    ) u_delay (
        .i_clk_sys (sys_clk),
        .sys_rst   (sys_rst),
        .i_clear   (clear),
        .i_en      (1'b1),
        .i_load    (ref_mark),
        .i_reload  (i_delay),
        .o_carry   (),
        .o_zpulse  (delay_z),
        .o_nzero   ()
    );

    // ------------------------------
    // Width former, strobe units
    // ------------------------------
    timing_counter #(
        .CNT_W (WFMR_W),
        .MODE  (pulse_timer_pkg::CNT_ONESHOT)
    ) u_width_fmr (
        .i_clk_sys (sys_clk),
        .sys_rst   (sys_rst),
        .i_clear   (clear),
        .i_en      (strobe),
        .i_load    (delay_z),
        .i_reload  (width_reload),
        .o_carry   (),
        .o_zpulse  (),
        .o_nzero   (o_pulse)
    );

    assign o_strobe = strobe;
    assign o_ref    = ref_mark;

endmodule

/* source/pulse_timer_pkg.sv */
package pulse_timer_pkg;

    // ------------------------------
    // Field widths
    // ------------------------------

    // Sample-rate divider reload, in sys_clk cycles
    localparam int SRATE_W = 8;

    // Pulse period reload, in sample strobes
    localparam int PERIOD_W = 23;

    // Delay reload, in sys_clk cycles
    localparam int DELAY_W = 9;

    // Pulse width reload, in sample strobes
    localparam int WIDTH_W = 16;

    // Register port
    localparam int REG_ADDR_W = 4;
    localparam int REG_DATA_W = 32;

    // ------------------------------
    // Counter mode
    // ------------------------------

    // Autoreload gives a periodic carry
    // One-shot counts down once after a load
    typedef enum logic {
        CNT_AUTORELOAD = 1'b0,
        CNT_ONESHOT    = 1'b1
    } counter_mode_t;

    // ------------------------------
    // Register map
    // ------------------------------

    // Control word, one enable bit per channel
    // Then four fields per channel, same order for each
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_CTRL       = 4'd0,
        REG_CH0_SRATE  = 4'd1,
        REG_CH0_PERIOD = 4'd2,
        REG_CH0_DELAY  = 4'd3,
        REG_CH0_WIDTH  = 4'd4,
        REG_CH1_SRATE  = 4'd5,
        REG_CH1_PERIOD = 4'd6,
        REG_CH1_DELAY  = 4'd7,
        REG_CH1_WIDTH  = 4'd8
    } reg_addr_t;

    // Anything else falls to the zero-read, write-ignore slot

endpackage

/* source/pulse_timer_top.sv */
module pulse_timer_top #(
    parameter int NUM_CH = 2
) (
    input  logic                                   sys_clk,
    input  logic                                   sys_rst,
    input  logic                                   i_req,
    input  logic                                   i_we,
    input  logic [pulse_timer_pkg::REG_ADDR_W-1:0] i_addr,
    input  logic [pulse_timer_pkg::REG_DATA_W-1:0] i_wdata,
    output logic                                   o_ack,
    output logic [pulse_timer_pkg::REG_DATA_W-1:0] o_rdata,
    output logic [NUM_CH-1:0]                      o_strobe,
    output logic [NUM_CH-1:0]                      o_ref,
    output logic [NUM_CH-1:0]                      o_pulse
);

    localparam int SW = pulse_timer_pkg::SRATE_W;
    localparam int PW = pulse_timer_pkg::PERIOD_W;
    localparam int LW = pulse_timer_pkg::DELAY_W;
    localparam int WW = pulse_timer_pkg::WIDTH_W;

    // Packed configuration, one slice per channel
    logic [NUM_CH-1:0]    enable;
    logic [NUM_CH*SW-1:0] srate_div;
    logic [NUM_CH*PW-1:0] period;
    logic [NUM_CH*LW-1:0] delay;
    logic [NUM_CH*WW-1:0] width;

    // ------------------------------
    // Register block
    // ------------------------------
    pulse_cfg_regs #(
        .NUM_CH (NUM_CH)
    ) u_cfg_regs (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .i_req       (i_req),
        .i_we        (i_we),
        .i_addr      (pulse_timer_pkg::reg_addr_t'(i_addr)),
        .i_wdata     (i_wdata),
        .o_ack       (o_ack),
        .o_rdata     (o_rdata),
        .o_enable    (enable),
        .o_srate_div (srate_div),
        .o_period    (period),
        .o_delay     (delay),
        .o_width     (width)
    );

    // ------------------------------
    // Pulse channels
    // ------------------------------
    for (genvar c = 0; c < NUM_CH; c++) begin : g_chan
        pulse_channel u_channel (
            .sys_clk     (sys_clk),
            .sys_rst     (sys_rst),
            .i_enable    (enable[c]),
            .i_srate_div (srate_div[c*SW +: SW]),
            .i_period    (period[c*PW +: PW]),
            .i_delay     (delay[c*LW +: LW]),
            .i_width     (width[c*WW +: WW]),
            .o_strobe    (o_strobe[c]),
            .o_ref       (o_ref[c]),
            .o_pulse     (o_pulse[c])
        );
    end

endmodule

/* source/timing_counter.sv */
module timing_counter #(
    parameter int CNT_W = 8,
    parameter pulse_timer_pkg::counter_mode_t MODE = pulse_timer_pkg::CNT_AUTORELOAD
) (
    input  logic             i_clk_sys,
    input  logic             sys_rst,
    input  logic             i_clear,
    input  logic             i_en,
    input  logic             i_load,
    input  logic [CNT_W-1:0] i_reload,
    output logic             o_carry,
    output logic             o_zpulse,
    output logic             o_nzero
);

    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             carry;
    logic             hit_zero;
    logic             zpulse_q;

    // ------------------------------
    // Next count
    // ------------------------------
    always_comb begin
        count_d  = count_q;
        carry    = 1'b0;
        hit_zero = 1'b0;
        if (i_clear) begin
            // Held at zero while the channel is off
            count_d = '0;
        end else if (MODE == pulse_timer_pkg::CNT_ONESHOT && i_load) begin
            count_d  = i_reload;
            // Zero load counts as an immediate expiry
            hit_zero = (i_reload == '0);
        end else if (i_en) begin
            if (count_q != '0) begin
                count_d  = count_q - 1'b1;
                hit_zero = (count_q == CNT_W'(1));
            end else if (MODE == pulse_timer_pkg::CNT_AUTORELOAD) begin
                // Wrap, one carry per reload+1 enabled cycles
                count_d = i_reload;
                carry   = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk_sys) begin
        if (sys_rst) begin
            count_q  <= '0;
            zpulse_q <= 1'b0;
        end else begin
            count_q  <= count_d;
            zpulse_q <= hit_zero;
        end
    end

    // Carry is same-cycle, zero pulse one cycle later
    assign o_carry  = carry;
    assign o_zpulse = zpulse_q & ~i_clear;
    assign o_nzero  = (count_q != '0) & ~i_clear;

endmodule

/* src.f */
source/pulse_timer_pkg.sv
source/timing_counter.sv
source/pulse_channel.sv
source/pulse_cfg_regs.sv
source/pulse_timer_top.sv
verification/pulse_timer_asserts.sv
verification/pulse_timer_tb.sv

/* verification/pulse_timer_asserts.sv */
module pulse_timer_asserts #(
    parameter bit CHECK_HS = 1'b1
) (
    input logic sys_clk,
    input logic sys_rst,
    input logic i_req,
    input logic o_ack,
    input logic i_enable,
    input logic o_pulse
);

    // ------------------------------
    // Register port handshake
    // ------------------------------
    if (CHECK_HS) begin : g_hs
        // Ack only answers a pending request
        ack_rise: assert property (@(posedge sys_clk) disable iff (sys_rst)
            (o_ack && !$past(o_ack)) |-> $past(i_req))
            else $error("o_ack rose with no request");

        // Ack drops only once the request is gone
        ack_fall: assert property (@(posedge sys_clk) disable iff (sys_rst)
            (!o_ack && $past(o_ack)) |-> !$past(i_req))
            else $error("o_ack fell while the request was still high");
    end else begin : g_pulse
        pulse_off: assert property (@(posedge sys_clk) disable iff (sys_rst)
            !i_enable |-> !o_pulse)
            else $error("o_pulse high on a disabled channel");
    end

endmodule

bind pulse_cfg_regs pulse_timer_asserts #(
    .CHECK_HS (1'b1)
) u_hs_asserts (
    .sys_clk  (sys_clk),
    .sys_rst  (sys_rst),
    .i_req    (i_req),
    .o_ack    (o_ack),
    .i_enable (1'b1),
    .o_pulse  (1'b0)
);

bind pulse_channel pulse_timer_asserts #(
    .CHECK_HS (1'b0)
) u_pulse_asserts (
    .sys_clk  (sys_clk),
    .sys_rst  (sys_rst),
    .i_req    (1'b0),
    .o_ack    (1'b0),
    .i_enable (i_enable),
    .o_pulse  (o_pulse)
);

/* verification/pulse_timer_tb.sv */
module pulse_timer_tb;

    localparam int NUM_CH   = 2;
    localparam int AW       = pulse_timer_pkg::REG_ADDR_W;
    localparam int DW       = pulse_timer_pkg::REG_DATA_W;
    localparam int WAIT_MAX = 2000;

    logic              sys_clk;
    logic              sys_rst;
    logic              i_req;
    logic              i_we;
    logic [AW-1:0]     i_addr;
    logic [DW-1:0]     i_wdata;
    logic              o_ack;
    logic [DW-1:0]     o_rdata;
    logic [NUM_CH-1:0] o_strobe;
    logic [NUM_CH-1:0] o_ref;
    logic [NUM_CH-1:0] o_pulse;

    integer            seed = 32'hdffe_1ce3;
    int                cyc = 0;
    int                errors = 0;
    int                checks = 0;
    // Channels whose outputs must stay low
    logic [NUM_CH-1:0] expect_off = '1;
    // Shadow register file indexed by address
    logic [DW-1:0]     shadow [16];

    pulse_timer_top #(
        .NUM_CH (NUM_CH)
    ) UUT (
        .sys_clk  (sys_clk),
        .sys_rst  (sys_rst),
        .i_req    (i_req),
        .i_we     (i_we),
        .i_addr   (i_addr),
        .i_wdata  (i_wdata),
        .o_ack    (o_ack),
        .o_rdata  (o_rdata),
        .o_strobe (o_strobe),
        .o_ref    (o_ref),
        .o_pulse  (o_pulse)
    );

    initial sys_clk = 1'b0;
    always #2 sys_clk = ~sys_clk;

    // Cycle stamp read at the falling edge
    always @(posedge sys_clk) cyc <= cyc + 1;

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_rdata(input pulse_timer_pkg::reg_addr_t addr,
                               input logic [DW-1:0] got, input logic [DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] o_rdata at 0x%0h got 0x%0h expected 0x%0h", addr, got, exp);
        end
    endtask

    task automatic check_interval(input string name, input int got, input int lo, input int hi);
        checks++;
        if (got < lo || got > hi) begin
            errors++;
            $display("[ERROR] %s got 0x%0h expected 0x%0h to 0x%0h", name, got, lo, hi);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // All three outputs of a disabled channel stay low
    always @(negedge sys_clk) begin
        if (!sys_rst) begin
            for (int c = 0; c < NUM_CH; c++) begin
                if (expect_off[c]) begin
                    check_level($sformatf("o_strobe[%0d]", c), o_strobe[c], 1'b0);
                    check_level($sformatf("o_ref[%0d]", c), o_ref[c], 1'b0);
                    check_level($sformatf("o_pulse[%0d]", c), o_pulse[c], 1'b0);
                end
            end
        end
    end

    // ------------------------------
    // Reference model helpers
    // ------------------------------
    // Implemented bits per address
    // Unmapped slots have none
    function automatic logic [DW-1:0] field_mask(input pulse_timer_pkg::reg_addr_t a);
        int n;
        case (a)
            pulse_timer_pkg::REG_CTRL:
                n = NUM_CH;
            pulse_timer_pkg::REG_CH0_SRATE, pulse_timer_pkg::REG_CH1_SRATE:
                n = pulse_timer_pkg::SRATE_W;
            pulse_timer_pkg::REG_CH0_PERIOD, pulse_timer_pkg::REG_CH1_PERIOD:
                n = pulse_timer_pkg::PERIOD_W;
            pulse_timer_pkg::REG_CH0_DELAY, pulse_timer_pkg::REG_CH1_DELAY:
                n = pulse_timer_pkg::DELAY_W;
            pulse_timer_pkg::REG_CH0_WIDTH, pulse_timer_pkg::REG_CH1_WIDTH:
                n = pulse_timer_pkg::WIDTH_W;
            default:
                n = 0;
        endcase
        return (DW'(1) << n) - DW'(1);
    endfunction

    // Four fields per channel after the control word
    // Order is srate then period then delay then width
    function automatic pulse_timer_pkg::reg_addr_t field_addr(input int c, input int f);
        return pulse_timer_pkg::reg_addr_t'(AW'(1 + 4 * c + f));
    endfunction

    function automatic string out_name(input int sel);
        return (sel == 0) ? "o_strobe" : (sel == 1) ? "o_ref" : "o_pulse";
    endfunction

    // ------------------------------
    // Register port
    // ------------------------------
    task automatic next_drive();
        @(posedge sys_clk);
        #1;
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (o_ack !== level && n < WAIT_MAX);
        if (o_ack !== level) begin
            errors++;
            $display("o_ack did not reach %0b within %0d cycles", level, WAIT_MAX);
        end
    endtask

    // Four-phase access with read data taken while ack is high
    task automatic access_reg(input pulse_timer_pkg::reg_addr_t addr, input logic we,
                              input logic [DW-1:0] data, output logic [DW-1:0] rdata);
        wait_ack(1'b0);
        next_drive();
        i_req   = 1'b1;
        i_we    = we;
        i_addr  = addr;
        i_wdata = data;
        wait_ack(1'b1);
        rdata = o_rdata;
        next_drive();
        i_req = 1'b0;
        i_we  = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic write_shadow(input pulse_timer_pkg::reg_addr_t addr,
                                input logic [DW-1:0] data);
        logic [DW-1:0] unused;
        access_reg(addr, 1'b1, data, unused);
        shadow[addr] = data & field_mask(addr);
    endtask

    task automatic set_enables(input logic [NUM_CH-1:0] en);
        next_drive();
        expect_off = expect_off & ~en;
        write_shadow(pulse_timer_pkg::REG_CTRL, DW'(en));
        next_drive();
        expect_off = ~en;
    endtask

    // Small random setup where each pulse ends before the next marker
    task automatic draw_config(input int c);
        int s;
        int p;
        int d;
        int w;
        int tries;
        tries = 0;
        do begin
            s = $unsigned($random(seed)) % 8;
            p = $unsigned($random(seed)) % 6;
            d = $unsigned($random(seed)) % 21;
            w = 1 + $unsigned($random(seed)) % 4;
            tries++;
        end while ((s + 1) * (p + 1) <= d + 4 + (w + 1) * (s + 1) && tries < 200);
        if ((s + 1) * (p + 1) <= d + 4 + (w + 1) * (s + 1)) begin
            s = 3;
            p = 5;
            d = 2;
            w = 1;
        end
        write_shadow(field_addr(c, 0), DW'(s));
        write_shadow(field_addr(c, 1), DW'(p));
        write_shadow(field_addr(c, 2), DW'(d));
        write_shadow(field_addr(c, 3), DW'(w));
    endtask

    // ------------------------------
    // Output timing
    // ------------------------------
    task automatic wait_out(input int sel, input int c, input logic level, output int stamp);
        int   n;
        logic v;
        n     = 0;
        stamp = -1;
        while (stamp < 0 && n < WAIT_MAX) begin
            @(negedge sys_clk);
            n++;
            v = (sel == 0) ? o_strobe[c] : (sel == 1) ? o_ref[c] : o_pulse[c];
            if (v === level) stamp = cyc;
        end
        if (stamp < 0) begin
            errors++;
            $display("%s[%0d] never reached %0b within %0d cycles", out_name(sel), c, level,
                     WAIT_MAX);
        end
    endtask

    task automatic timing_run(input string tag, input int c);
        int s;
        int p;
        int d;
        int w;
        int a;
        int b;
        int t1;
        int t2;
        int r;
        int f;
        int e0;
        e0 = errors;
        s  = int'(shadow[field_addr(c, 0)]);
        p  = int'(shadow[field_addr(c, 1)]);
        d  = int'(shadow[field_addr(c, 2)]);
        w  = int'(shadow[field_addr(c, 3)]);
        wait_out(0, c, 1'b1, a);
        wait_out(0, c, 1'b1, b);
        // Marker then rise and fall of its pulse then the next marker
        wait_out(1, c, 1'b1, t1);
        wait_out(2, c, 1'b1, r);
        wait_out(2, c, 1'b0, f);
        wait_out(1, c, 1'b1, t2);
        check_interval($sformatf("o_strobe[%0d] spacing", c), b - a, s + 1, s + 1);
        check_interval($sformatf("o_ref[%0d] spacing", c), t2 - t1,
                       (s + 1) * (p + 1), (s + 1) * (p + 1));
        check_interval($sformatf("o_pulse[%0d] delay", c), r - t1, d + 2, d + 2);
        check_interval($sformatf("o_pulse[%0d] width", c), f - r,
                       w * (s + 1), (w + 1) * (s + 1));
        $display("%s ch%0d srate %0d period %0d delay %0d width %0d: %0d errors",
                 tag, c, s, p, d, w, errors - e0);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [DW-1:0] got;
        int            e0;
        sys_rst = 1'b1;
        i_req   = 1'b0;
        i_we    = 1'b0;
        i_addr  = '0;
        i_wdata = '0;
        for (int a = 0; a < 16; a++) begin
            shadow[a] = '0;
        end
        repeat (10) @(posedge sys_clk);
        #1;
        sys_rst = 1'b0;

        // Everything idle out of reset
        // Ack low with no request pending
        e0 = errors;
        repeat (20) begin
            @(negedge sys_clk);
            check_level("o_ack", o_ack, 1'b0);
        end
        $display("reset state: %0d errors", errors - e0);

        // Random data written to every address and read back
        e0 = errors;
        next_drive();
        expect_off = '0;
        for (int a = 0; a < 16; a++) begin
            write_shadow(pulse_timer_pkg::reg_addr_t'(AW'(a)), $random(seed));
        end
        for (int a = 0; a < 16; a++) begin
            access_reg(pulse_timer_pkg::reg_addr_t'(AW'(a)), 1'b0, '0, got);
            check_rdata(pulse_timer_pkg::reg_addr_t'(AW'(a)), got, shadow[a]);
        end
        set_enables('0);
        $display("register readback: %0d errors", errors - e0);

        // One channel at a time with a fresh setup each round
        for (int round = 0; round < 3; round++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                set_enables('0);
                draw_config(c);
                set_enables(NUM_CH'(1 << c));
                timing_run("single", c);
            end
        end

        // Both running and then each alone with the other parked
        set_enables('0);
        draw_config(0);
        draw_config(1);
        set_enables(2'b11);
        timing_run("both on", 0);
        timing_run("both on", 1);
        set_enables(2'b01);
        timing_run("ch1 off", 0);
        set_enables(2'b10);
        timing_run("ch0 off", 1);
        set_enables('0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
